// File: sources.f
+incdir+src
+incdir+tb
src/bus_pkg.sv
src/input_sync.sv
src/bus_transaction_fsm.sv
src/gearbox_ram.sv
src/playback_sequencer.sv
src/parallel_bus_slave_top.sv
tb/tb_parallel_bus.sv

// File: src/bus_defines.svh
/*
 parallel bus slave: widths, depths and pipeline delays
*/
`ifndef BUS_DEFINES_SVH
`define BUS_DEFINES_SVH

// --------------------
// host bus
`define BUS_WIDTH 16
`define HALVES_PER_WORD 2 // bus transactions per data word
`define WORD_WIDTH 32

// --------------------
// memory
`define ADDR_BITS 8 // word address
`define BYTE_ADDR_BITS 10 // playback side, bytes
`define PLAYBACK_LENGTH 64 // bytes per loop

// --------------------
// timing
`define SYNC_DEPTH 3 // input sampling stages
`define ACK_DELAY 4 // extra stages on ack_valid

// --------------------
// status
`define ERR_WIDTH 16

`endif

// File: src/bus_pkg.sv
/*
 shared types for the parallel bus slave: control lines, request kinds,
 sequencer phases and the memory, error and playback bundles
*/
`include "bus_defines.svh"

package bus_pkg;

	// --------------------
	// host side
	typedef struct packed {
		logic read; // 0=write, 1=read
		logic register_select; // 0=address, 1=data
		logic enable; // 1=active
	} host_ctrl_t;

	// decoded kind of a stable request
	typedef enum logic [1:0] {
		XFER_NONE,
		XFER_ADDRESS,
		XFER_WRITE,
		XFER_READ
	} xfer_kind_e;

	// one per sequencer
	typedef enum logic [1:0] {
		PH_IDLE,
		PH_LATCHED, // halfword taken, waiting for release
		PH_WORD_DONE // last halfword released
	} seq_phase_e;

	// --------------------
	// memory and status
	typedef struct packed {
		logic [`ADDR_BITS-1:0] addr;
		logic [`WORD_WIDTH-1:0] data;
		logic strobe;
	} ram_write_t;

	typedef struct packed {
		logic [`ERR_WIDTH-1:0] read_errors;
		logic [`ERR_WIDTH-1:0] write_errors;
		logic [`ERR_WIDTH-1:0] address_errors;
	} error_counts_t;

	typedef struct packed {
		logic [7:0] data;
		logic sync; // high with byte 0 of the loop
	} playback_t;

endpackage

// File: src/bus_transaction_fsm.sv
/*
 bus transaction engine: address, write and read halfword sequencers,
 word address with auto-increment, error counts and the delayed ack
*/
`include "bus_defines.svh"

module bus_transaction_fsm import bus_pkg::*; (
	input logic clock,
	input logic reset125,
	input xfer_kind_e kind,
	input logic idle,
	input logic [`BUS_WIDTH-1:0] bus_word,
	input logic [`WORD_WIDTH-1:0] read_word,
	output ram_write_t ram_wr,
	output logic ack_valid,
	output logic [`BUS_WIDTH-1:0] bus_out,
	output error_counts_t errors
);

	localparam int PTR_BITS = $clog2(`HALVES_PER_WORD);
	localparam logic [PTR_BITS-1:0] PTR_MS = PTR_BITS'(`HALVES_PER_WORD - 1);

	seq_phase_e addr_phase;
	seq_phase_e write_phase;
	seq_phase_e read_phase;
	logic [PTR_BITS-1:0] write_ptr; // counts down, most significant half first
	logic [PTR_BITS-1:0] read_ptr;
	logic [`ADDR_BITS-1:0] addr_hold;
	logic [`ADDR_BITS-1:0] address;
	logic [`WORD_WIDTH-1:0] write_word;
	logic write_strobe;
	logic ack_int;
	logic [`ACK_DELAY-1:0] ack_pipe;

	logic step_addr, step_write, step_read;
	logic mid_addr, mid_write, mid_read;
	logic drop_addr, drop_write, drop_read;

	// --------------------
	// release decode
	assign step_addr = idle && (addr_phase == PH_LATCHED);
	assign step_write = idle && (write_phase == PH_LATCHED);
	assign step_read = idle && (read_phase == PH_LATCHED);

	// address is a single step, so only a pending latch counts
	assign mid_addr = (addr_phase == PH_LATCHED);
	assign mid_write = (write_phase == PH_LATCHED) ||
		((write_phase == PH_IDLE) && (write_ptr != PTR_MS));
	assign mid_read = (read_phase == PH_LATCHED) ||
		((read_phase == PH_IDLE) && (read_ptr != PTR_MS));

	assign drop_addr = (step_write || step_read) && mid_addr;
	assign drop_write = (step_addr || step_read) && mid_write;
	assign drop_read = (step_addr || step_write) && mid_read;

	// --------------------
	// sequencers
	always_ff @(posedge clock) begin
		if (reset125) begin
			addr_phase <= PH_IDLE;
			write_phase <= PH_IDLE;
			read_phase <= PH_IDLE;
			write_ptr <= PTR_MS;
			read_ptr <= PTR_MS;
			address <= '0;
			write_strobe <= 1'b0;
			ack_int <= 1'b0;
			errors <= '0;
		end else begin
			write_strobe <= 1'b0;
			if (kind != XFER_NONE) begin
				ack_int <= 1'b1;
				case (kind)
					XFER_ADDRESS: if (addr_phase == PH_IDLE) addr_phase <= PH_LATCHED;
					XFER_WRITE: if (write_phase == PH_IDLE) write_phase <= PH_LATCHED;
					XFER_READ: if (read_phase == PH_IDLE) read_phase <= PH_LATCHED;
					default: ;
				endcase
			end else if (idle) begin
				ack_int <= 1'b0;
				// address
				if (step_addr) begin
					addr_phase <= PH_WORD_DONE;
				end else if (drop_addr) begin
					addr_phase <= PH_IDLE;
					errors.address_errors <= errors.address_errors + 1'b1;
				end else if (addr_phase == PH_WORD_DONE) begin
					addr_phase <= PH_IDLE;
					address <= addr_hold; // load
				end
				// write
				if (step_write) begin
					if (write_ptr == '0) begin
						write_phase <= PH_WORD_DONE;
						write_strobe <= 1'b1;
					end else begin
						write_phase <= PH_IDLE;
						write_ptr <= write_ptr - 1'b1;
					end
				end else if (drop_write) begin
					write_phase <= PH_IDLE;
					write_ptr <= PTR_MS;
					errors.write_errors <= errors.write_errors + 1'b1;
				end else if (write_phase == PH_WORD_DONE) begin
					write_phase <= PH_IDLE;
					write_ptr <= PTR_MS;
					address <= address + 1'b1; // auto-increment
				end
				// read
				if (step_read) begin
					if (read_ptr == '0) begin
						read_phase <= PH_WORD_DONE;
					end else begin
						read_phase <= PH_IDLE;
						read_ptr <= read_ptr - 1'b1;
					end
				end else if (drop_read) begin
					read_phase <= PH_IDLE;
					read_ptr <= PTR_MS;
					errors.read_errors <= errors.read_errors + 1'b1;
				end else if (read_phase == PH_WORD_DONE) begin
					read_phase <= PH_IDLE;
					read_ptr <= PTR_MS;
					address <= address + 1'b1;
				end
			end
		end
	end

	// halfword capture, taken once per request
	always_ff @(posedge clock) begin
		if ((kind == XFER_ADDRESS) && (addr_phase == PH_IDLE)) begin
			addr_hold <= bus_word[`ADDR_BITS-1:0];
		end
		if ((kind == XFER_WRITE) && (write_phase == PH_IDLE)) begin
			write_word[write_ptr*`BUS_WIDTH +: `BUS_WIDTH] <= bus_word;
		end
		if ((kind == XFER_READ) && (read_phase == PH_IDLE)) begin
			bus_out <= read_word[read_ptr*`BUS_WIDTH +: `BUS_WIDTH];
		end
	end

	// --------------------
	// ack
	always_ff @(posedge clock) begin
		if (reset125) begin
			ack_pipe <= '0;
		end else begin
			ack_pipe <= {ack_pipe[`ACK_DELAY-2:0], ack_int};
		end
	end

	assign ack_valid = ack_pipe[`ACK_DELAY-1];
	assign ram_wr = '{addr: address, data: write_word, strobe: write_strobe};

	// strobe lands while the word is still marked done, before the address moves
	a_strobe_in_done: assert property (@(posedge clock) disable iff (reset125)
		write_strobe |-> (write_phase == PH_WORD_DONE));

	a_one_latched: assert property (@(posedge clock) disable iff (reset125)
		$onehot0({addr_phase == PH_LATCHED, write_phase == PH_LATCHED,
			read_phase == PH_LATCHED}));

endmodule

// File: src/gearbox_ram.sv
/*
 dual-port word memory: 32-bit read/write host port and an 8-bit
 read-only playback port over the same storage
*/
`include "bus_defines.svh"

module gearbox_ram import bus_pkg::*; (
	input logic clock,
	input ram_write_t port_a,
	output logic [`WORD_WIDTH-1:0] read_word,
	input logic [`BYTE_ADDR_BITS-1:0] byte_addr,
	output logic [7:0] byte_data
);

	localparam int DEPTH = 2 ** `ADDR_BITS;
	localparam int LANE_BITS = $clog2(`WORD_WIDTH / 8); // bytes per word

	logic [`WORD_WIDTH-1:0] mem [DEPTH];
	logic [`ADDR_BITS-1:0] word_sel;
	logic [LANE_BITS-1:0] lane_sel;
	logic [`WORD_WIDTH-1:0] word_b;

	// --------------------
	// port a, host side
	always_ff @(posedge clock) begin
		if (port_a.strobe) begin
			mem[port_a.addr] <= port_a.data;
		end
		read_word <= mem[port_a.addr]; // new data shows one cycle after the write
	end

	// --------------------
	// port b, byte lanes
	assign word_sel = byte_addr[`BYTE_ADDR_BITS-1:LANE_BITS];
	assign lane_sel = byte_addr[LANE_BITS-1:0];
	assign word_b = mem[word_sel];

	always_ff @(posedge clock) begin
		byte_data <= word_b[lane_sel*8 +: 8]; // lane 0 is the low byte
	end

endmodule

// File: src/input_sync.sv
/*
 input sampling for the host bus: shift pipelines on the control lines
 and data, decoded into a stable request kind or a stable release
*/
`include "bus_defines.svh"

module input_sync import bus_pkg::*; (
	input logic clock,
	input logic reset125,
	input host_ctrl_t host,
	input logic [`BUS_WIDTH-1:0] bus_in,
	output xfer_kind_e kind,
	output logic idle,
	output logic [`BUS_WIDTH-1:0] bus_word,
	output logic read_level
);

	host_ctrl_t ctrl_pipe [`SYNC_DEPTH];
	logic [`BUS_WIDTH-1:0] bus_pipe [`SYNC_DEPTH];
	host_ctrl_t last_ctrl;
	host_ctrl_t prev_ctrl;
	logic agree;

	assign last_ctrl = ctrl_pipe[`SYNC_DEPTH-1];
	assign prev_ctrl = ctrl_pipe[`SYNC_DEPTH-2];
	assign agree = (last_ctrl == prev_ctrl); // one-sample glitch filter
	assign read_level = last_ctrl.read;

	// --------------------
	// control lines
	always_ff @(posedge clock) begin
		if (reset125) begin
			for (int i = 0; i < `SYNC_DEPTH; i++) begin
				ctrl_pipe[i] <= '0;
			end
			kind <= XFER_NONE;
			idle <= 1'b0;
		end else begin
			ctrl_pipe[0] <= host;
			for (int i = 1; i < `SYNC_DEPTH; i++) begin
				ctrl_pipe[i] <= ctrl_pipe[i-1];
			end
			kind <= XFER_NONE;
			if (agree && last_ctrl.enable) begin
				if (last_ctrl.read) kind <= XFER_READ;
				else if (last_ctrl.register_select) kind <= XFER_WRITE;
				else kind <= XFER_ADDRESS;
			end
			idle <= !last_ctrl.enable && !prev_ctrl.enable;
		end
	end

	// data follows the same depth, plus the decode stage
	always_ff @(posedge clock) begin
		bus_pipe[0] <= bus_in;
		for (int i = 1; i < `SYNC_DEPTH; i++) begin
			bus_pipe[i] <= bus_pipe[i-1];
		end
		bus_word <= bus_pipe[`SYNC_DEPTH-1];
	end

endmodule

// File: src/parallel_bus_slave_top.sv
/*
 parallel bus slave with pollable memory and looping byte playback
*/
`include "bus_defines.svh"

module parallel_bus_slave_top import bus_pkg::*; (
	input logic clock,
	input logic reset125,
	input host_ctrl_t host,
	input logic [`BUS_WIDTH-1:0] bus_in,
	output logic [`BUS_WIDTH-1:0] bus_out,
	output logic bus_out_enable,
	output logic ack_valid,
	output error_counts_t errors,
	output playback_t playback
);

	xfer_kind_e kind;
	logic idle;
	logic [`BUS_WIDTH-1:0] bus_word;
	logic [`WORD_WIDTH-1:0] read_word;
	ram_write_t ram_wr;
	logic [`BYTE_ADDR_BITS-1:0] byte_addr;
	logic [7:0] byte_data;

	// --------------------
	// host side
	input_sync sync0 (
		.clock(clock),
		.reset125(reset125),
		.host(host),
		.bus_in(bus_in),
		.kind(kind),
		.idle(idle),
		.bus_word(bus_word),
		.read_level(bus_out_enable) // drive while the host reads
	);

	bus_transaction_fsm fsm0 (
		.clock(clock),
		.reset125(reset125),
		.kind(kind),
		.idle(idle),
		.bus_word(bus_word),
		.read_word(read_word),
		.ram_wr(ram_wr),
		.ack_valid(ack_valid),
		.bus_out(bus_out),
		.errors(errors)
	);

	// --------------------
	// storage and playback
	gearbox_ram ram0 (
		.clock(clock),
		.port_a(ram_wr),
		.read_word(read_word),
		.byte_addr(byte_addr),
		.byte_data(byte_data)
	);

	playback_sequencer play0 (
		.clock(clock),
		.reset125(reset125),
		.byte_addr(byte_addr),
		.byte_data(byte_data),
		.playback(playback)
	);

endmodule

// File: src/playback_sequencer.sv
/*
 playback loop: byte address counter over the first PLAYBACK_LENGTH
 bytes, with a sync flag on byte 0
*/
`include "bus_defines.svh"

module playback_sequencer import bus_pkg::*; (
	input logic clock,
	input logic reset125,
	output logic [`BYTE_ADDR_BITS-1:0] byte_addr,
	input logic [7:0] byte_data,
	output playback_t playback
);

	localparam logic [`BYTE_ADDR_BITS-1:0] LAST_ADDR =
		`BYTE_ADDR_BITS'(`PLAYBACK_LENGTH - 1);

	logic loop_start;
	logic sync_q;

	assign loop_start = (byte_addr == '0);

	// --------------------
	// address counter
	always_ff @(posedge clock) begin
		if (reset125) begin
			byte_addr <= '0;
			sync_q <= 1'b0;
		end else begin
			if (byte_addr == LAST_ADDR) begin
				byte_addr <= '0; // wrap
			end else begin
				byte_addr <= byte_addr + 1'b1;
			end
			sync_q <= loop_start; // one cycle of ram latency
		end
	end

	assign playback = '{data: byte_data, sync: sync_q};

	a_addr_in_loop: assert property (@(posedge clock) disable iff (reset125)
		byte_addr < `PLAYBACK_LENGTH);

endmodule

// File: tb/tb_bus_tasks.svh
/*
 host-side tasks for the parallel bus testbench: handshakes, stimulus LFSR,
 memory model and typed compare tasks
*/
`ifndef TB_BUS_TASKS_SVH
`define TB_BUS_TASKS_SVH

// --------------------
// stimulus and model
logic [15:0] lfsr_state = LFSR_SEED;
logic [`WORD_WIDTH-1:0] model_mem [2**`ADDR_BITS];
logic [`ADDR_BITS-1:0] model_addr = '0; // expected DUT address

// galois form, one step per bit taken
function automatic logic [`WORD_WIDTH-1:0] lfsr_word();
	logic [`WORD_WIDTH-1:0] word;
	for (int i = 0; i < `WORD_WIDTH; i++) begin
		word = {word[`WORD_WIDTH-2:0], lfsr_state[0]};
		lfsr_state = {1'b0, lfsr_state[15:1]} ^ (lfsr_state[0] ? 16'hB400 : 16'h0000);
	end
	return word;
endfunction

task automatic model_apply(input ram_write_t entry);
	if (entry.strobe) begin
		model_mem[entry.addr] = entry.data;
	end
endtask

// --------------------
// four-phase handshake, one halfword
task automatic bus_handshake(input xfer_kind_e kind, input logic [`BUS_WIDTH-1:0] data,
		output logic [`BUS_WIDTH-1:0] response);
	int waited;
	@(posedge clock);
	host.read <= (kind == XFER_READ);
	host.register_select <= (kind != XFER_ADDRESS);
	bus_in <= data;
	@(posedge clock);
	host.enable <= 1'b1; // lines settled one cycle earlier
	waited = 0;
	while (ack_valid !== 1'b1) begin
		@(posedge clock);
		waited++;
		if (waited > ACK_WAIT) stop_with_failure("ack_valid never rose after enable went high");
	end
	response = bus_out; // valid while ack is high
	compare_level("bus_out_enable while ack is high", kind == XFER_READ, bus_out_enable);
	host.enable <= 1'b0;
	waited = 0;
	while (ack_valid !== 1'b0) begin
		@(posedge clock);
		waited++;
		if (waited > ACK_WAIT) stop_with_failure("ack_valid never fell after enable went low");
	end
endtask

task automatic host_address(input logic [`ADDR_BITS-1:0] addr);
	logic [`BUS_WIDTH-1:0] ignored;
	bus_handshake(XFER_ADDRESS, `BUS_WIDTH'(addr), ignored);
	model_addr = addr;
endtask

task automatic host_write_word(input logic [`WORD_WIDTH-1:0] data);
	ram_write_t entry;
	logic [`BUS_WIDTH-1:0] ignored;
	bus_handshake(XFER_WRITE, data[`WORD_WIDTH-1 -: `BUS_WIDTH], ignored); // upper half first
	bus_handshake(XFER_WRITE, data[`BUS_WIDTH-1:0], ignored);
	entry.addr = model_addr;
	entry.data = data;
	entry.strobe = 1'b1;
	model_apply(entry);
	model_addr = model_addr + 1'b1;
endtask

task automatic host_read_word(output logic [`WORD_WIDTH-1:0] data);
	logic [`BUS_WIDTH-1:0] upper;
	logic [`BUS_WIDTH-1:0] lower;
	bus_handshake(XFER_READ, '0, upper);
	bus_handshake(XFER_READ, '0, lower);
	data = {upper, lower};
	model_addr = model_addr + 1'b1;
endtask

// --------------------
// compare tasks
task automatic compare_word(input string what, input logic [`WORD_WIDTH-1:0] expected,
		input logic [`WORD_WIDTH-1:0] actual);
	if (actual !== expected) begin
		stop_with_failure($sformatf("** Error at %0t: %s expected %h, got %h",
			$time, what, expected, actual));
	end
endtask

task automatic compare_errors(input string what, input error_counts_t expected,
		input error_counts_t actual);
	if (actual !== expected) begin
		stop_with_failure($sformatf(
			"** Error at %0t: %s expected r/w/a %0d/%0d/%0d, got %0d/%0d/%0d", $time, what,
			expected.read_errors, expected.write_errors, expected.address_errors,
			actual.read_errors, actual.write_errors, actual.address_errors));
	end
endtask

task automatic compare_byte(input string what, input playback_t expected,
		input playback_t actual);
	if (actual !== expected) begin
		stop_with_failure($sformatf("** Error at %0t: %s expected %h sync %b, got %h sync %b",
			$time, what, expected.data, expected.sync, actual.data, actual.sync));
	end
endtask

task automatic compare_level(input string what, input logic expected, input logic actual);
	if (actual !== expected) begin
		stop_with_failure($sformatf("** Error at %0t: %s expected %b, got %b",
			$time, what, expected, actual));
	end
endtask

`endif

// File: tb/tb_parallel_bus.sv
/*
 testbench for the parallel bus slave: host handshakes, memory read-back,
 error counting and the playback loop
*/
`include "bus_defines.svh"

module tb_parallel_bus import bus_pkg::*; ();

	localparam logic [15:0] LFSR_SEED = 16'd62826;
	localparam int ACK_WAIT = 40; // cycles, nominal ack latency is 9
	localparam int FILL_WORDS = `PLAYBACK_LENGTH / 4;
	localparam int HANDSHAKES = (2 + 4 * FILL_WORDS) + (1 + 4) + 13;
	localparam int CYCLE_LIMIT = 2 * (60 * HANDSHAKES + 3 * `PLAYBACK_LENGTH);
	localparam logic [`ADDR_BITS-1:0] MID_ADDR = 8'd7;
	localparam logic [`ADDR_BITS-1:0] ERR_ADDR = 8'd12; // still inside the playback loop

	logic clock;
	logic reset125;
	host_ctrl_t host;
	logic [`BUS_WIDTH-1:0] bus_in;
	logic [`BUS_WIDTH-1:0] bus_out;
	logic bus_out_enable;
	logic ack_valid;
	error_counts_t errors;
	playback_t playback;
	int cycle_count = 0;

	parallel_bus_slave_top dut0 (
		.clock(clock),
		.reset125(reset125),
		.host(host),
		.bus_in(bus_in),
		.bus_out(bus_out),
		.bus_out_enable(bus_out_enable),
		.ack_valid(ack_valid),
		.errors(errors),
		.playback(playback)
	);

	task automatic stop_with_failure(input string reason);
		$display("%s", reason);
		$display("STATUS: FAIL");
		$fatal(1, "run stopped");
	endtask

	`include "tb_bus_tasks.svh"

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	// run limit
	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count > CYCLE_LIMIT) begin
			stop_with_failure($sformatf("timeout, run exceeded %0d clock cycles", CYCLE_LIMIT));
		end
	end

	task automatic read_and_check(input string what);
		logic [`ADDR_BITS-1:0] addr;
		logic [`WORD_WIDTH-1:0] actual;
		addr = model_addr;
		host_read_word(actual);
		compare_word($sformatf("%s, word %0d", what, addr), model_mem[addr], actual);
	endtask

	// --------------------
	// tests
	task automatic check_reset_state();
		error_counts_t zero;
		zero = '0;
		@(posedge clock);
		compare_level("ack_valid after reset", 1'b0, ack_valid);
		compare_level("bus_out_enable after reset", 1'b0, bus_out_enable);
		compare_errors("error counts after reset", zero, errors);
	endtask

	task automatic fill_and_read_back();
		host_address('0);
		for (int i = 0; i < FILL_WORDS; i++) host_write_word(lfsr_word());
		host_address('0);
		for (int i = 0; i < FILL_WORDS; i++) read_and_check("fill read-back");
	endtask

	task automatic read_from_mid_range();
		host_address(MID_ADDR);
		read_and_check("mid-range read");
		read_and_check("mid-range next word"); // auto-increment
	endtask

	task automatic abandon_partial_words();
		error_counts_t expected;
		logic [`BUS_WIDTH-1:0] ignored;
		expected = '0;
		host_address(ERR_ADDR);
		bus_handshake(XFER_WRITE, 16'h5a5a, ignored); // half a word only
		host_address(ERR_ADDR);
		expected.write_errors = 1;
		compare_errors("after the abandoned write", expected, errors);
		bus_handshake(XFER_READ, '0, ignored);
		host_write_word(lfsr_word()); // drops the pending read
		expected.read_errors = 1;
		compare_errors("after the abandoned read", expected, errors);
		host_write_word(lfsr_word());
		host_address(ERR_ADDR);
		read_and_check("read-back after errors");
		read_and_check("read-back after errors");
	endtask

	task automatic capture_playback_loop();
		playback_t expected;
		int waited;
		waited = 0;
		while (playback.sync !== 1'b1) begin
			@(posedge clock);
			waited++;
			if (waited > `PLAYBACK_LENGTH + 2) stop_with_failure("playback sync never arrived");
		end
		for (int k = 0; k < `PLAYBACK_LENGTH; k++) begin
			expected.data = model_mem[k / 4][(k % 4) * 8 +: 8]; // byte 0 is the low lane
			expected.sync = (k == 0);
			compare_byte($sformatf("playback byte %0d", k), expected, playback);
			@(posedge clock);
		end
		expected.data = model_mem[0][7:0];
		expected.sync = 1'b1;
		compare_byte("sync after the last byte", expected, playback);
	endtask

	// --------------------
	// test order
	initial begin
		reset125 = 1'b1;
		host = '0;
		bus_in = '0;
		repeat (4) @(posedge clock);
		reset125 <= 1'b0;
		check_reset_state();
		fill_and_read_back();
		read_from_mid_range();
		abandon_partial_words();
		capture_playback_loop();
		$display("STATUS: PASS");
		$finish;
	end

endmodule
